// File: hdl/lsu_consts.svh
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// widths of the load/store unit, fixed by the instruction set

// data and address width
`define LSU_DATA_BITS 32

// opcode field coming from decode
`define LSU_OP_BITS 4

// register file index
`define LSU_REG_BITS 5

// one strobe bit per byte lane
`define LSU_STRB_BITS 4

`endif

// File: hdl/lsu_op_pkg.sv
`include "lsu_consts.svh"

package lsu_op_pkg;

   // memory opcodes issued by the execute stage
   typedef enum logic [`LSU_OP_BITS-1:0] {
      LD_B  = 4'h0,
      LD_H  = 4'h1,
      LD_W  = 4'h2,
      LD_BU = 4'h3,
      LD_HU = 4'h4,
      ST_B  = 4'h5,
      ST_H  = 4'h6,
      ST_W  = 4'h7,
      // load-linked / store-conditional pair, word only
      LL_W  = 4'h8,
      SC_W  = 4'h9,
      NOP   = 4'hf
   } lsu_op_e;

   // access size, drives alignment, strobes and extraction
   typedef enum logic [1:0] {
      SIZE_B = 2'd0,
      SIZE_H = 2'd1,
      SIZE_W = 2'd2
   } lsu_size_e;

endpackage

// File: hdl/mem_port_pkg.sv
`include "lsu_consts.svh"

package mem_port_pkg;

   // memory port payload
   typedef logic [`LSU_DATA_BITS-1:0] lsu_addr_t;
   typedef logic [`LSU_DATA_BITS-1:0] lsu_data_t;
   typedef logic [`LSU_STRB_BITS-1:0] lsu_strb_t;

   // writeback destination
   typedef logic [`LSU_REG_BITS-1:0]  lsu_reg_t;

endpackage

// File: hdl/lsu_op_decode.sv
`include "lsu_consts.svh"

module lsu_op_decode import lsu_op_pkg::*; (
   input  lsu_op_e   op,
   output lsu_size_e size,
   output logic      is_unsigned,
   output logic      is_store,
   output logic      is_ll,
   output logic      is_sc
);

   always_comb begin
      // NOP keeps every flag clear
      size        = SIZE_B;
      is_unsigned = 1'b0;
      is_store    = 1'b0;
      is_ll       = 1'b0;
      is_sc       = 1'b0;
      case (op)
         LD_B: begin
            size = SIZE_B;
         end
         LD_H: begin
            size = SIZE_H;
         end
         LD_W: begin
            size = SIZE_W;
         end
         LD_BU: begin
            size        = SIZE_B;
            is_unsigned = 1'b1;
         end
         LD_HU: begin
            size        = SIZE_H;
            is_unsigned = 1'b1;
         end
         ST_B: begin
            size     = SIZE_B;
            is_store = 1'b1;
         end
         ST_H: begin
            size     = SIZE_H;
            is_store = 1'b1;
         end
         ST_W: begin
            size     = SIZE_W;
            is_store = 1'b1;
         end
         LL_W: begin
            size  = SIZE_W;
            is_ll = 1'b1;
         end
         // sc writes memory, so it goes out as a store
         SC_W: begin
            size     = SIZE_W;
            is_store = 1'b1;
            is_sc    = 1'b1;
         end
         default: begin
            size = SIZE_B;
         end
      endcase
   end

endmodule

// File: hdl/lsu_issue.sv
`include "lsu_consts.svh"

module lsu_issue import lsu_op_pkg::*, mem_port_pkg::*; (
   input  logic      valid,
   input  lsu_op_e   op,
   input  lsu_data_t base,
   input  lsu_data_t offset,
   input  lsu_data_t wdata,
   output logic      data_req,
   output lsu_addr_t data_addr,
   output logic      data_wr,
   output lsu_strb_t data_wstrb,
   output lsu_data_t data_wdata,
   output logic      data_ll,
   output logic      data_sc,
   output logic      ale,
   input  logic      data_addr_ok,
   output logic      addr_finish
);

   lsu_size_e size;
   logic      is_store;
   logic      is_ll;
   logic      is_sc;
   lsu_addr_t addr;
   logic      misaligned;

   lsu_op_decode decode_inst (
      .op          (op),
      .size        (size),
      .is_unsigned (),
      .is_store    (is_store),
      .is_ll       (is_ll),
      .is_sc       (is_sc)
   );

   assign addr = base + offset;

   // halfword needs bit 0 clear, word (and ll/sc) needs bits 1:0 clear
   always_comb begin
      case (size)
         SIZE_H:  misaligned = addr[0];
         SIZE_W:  misaligned = addr[1:0] != 2'b00;
         default: misaligned = 1'b0;
      endcase
   end

   assign ale      = valid & misaligned;
   assign data_req = valid & ~ale;

   // done with the address phase once accepted or trapped
   assign addr_finish = (data_req & data_addr_ok) | ale;

   assign data_addr = addr;
   assign data_wr   = is_store;
   assign data_ll   = is_ll;
   assign data_sc   = is_sc;

   // lanes selected by the byte offset, data replicated across the word
   always_comb begin
      data_wstrb = '0;
      data_wdata = '0;
      if (is_store) begin
         case (size)
            SIZE_B: begin
               data_wstrb = lsu_strb_t'(`LSU_STRB_BITS'b0001) << addr[1:0];
               data_wdata = {4{wdata[7:0]}};
            end
            SIZE_H: begin
               data_wstrb = lsu_strb_t'(`LSU_STRB_BITS'b0011) << addr[1:0];
               data_wdata = {2{wdata[15:0]}};
            end
            default: begin
               data_wstrb = '1;
               data_wdata = wdata;
            end
         endcase
      end
   end

endmodule

// File: hdl/lsu_mem_track.sv
`include "lsu_consts.svh"

module lsu_mem_track import lsu_op_pkg::*, mem_port_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  logic       valid,
   input  lsu_op_e    op_e,
   input  logic [1:0] addr_low_e,
   input  lsu_reg_t   rd_e,
   input  logic       wen_e,
   input  logic       accepted,
   input  logic       data_data_ok,
   output lsu_op_e    op_m,
   output logic [1:0] addr_low_m,
   output lsu_reg_t   rd_m,
   output logic       wen_m,
   output logic       data_recv
);

   // low address bits are kept so the memory stage needs no second adder
   always_ff @(posedge clk) begin
      if (valid) begin
         op_m       <= op_e;
         addr_low_m <= addr_low_e;
         rd_m       <= rd_e;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wen_m <= 1'b0;
      end else if (valid) begin
         wen_m <= wen_e;
      end
   end

   // busy from the cycle after acceptance until data comes back
   always_ff @(posedge clk) begin
      if (reset) begin
         data_recv <= 1'b0;
      end else if (accepted) begin
         data_recv <= 1'b1;
      end else if (data_data_ok) begin
         data_recv <= 1'b0;
      end
   end

endmodule

// File: hdl/lsu_load_align.sv
`include "lsu_consts.svh"

module lsu_load_align import lsu_op_pkg::*, mem_port_pkg::*; (
   input  lsu_op_e    op_m,
   input  logic [1:0] addr_low_m,
   input  lsu_data_t  data_rdata,
   input  logic       data_scsucceed,
   output lsu_data_t  read_result_m
);

   lsu_size_e   size;
   logic        is_unsigned;
   logic        is_store;
   logic        is_sc;
   logic [7:0]  byte_sel;
   logic [15:0] half_sel;
   logic        byte_sign;
   logic        half_sign;

   lsu_op_decode decode_inst (
      .op          (op_m),
      .size        (size),
      .is_unsigned (is_unsigned),
      .is_store    (is_store),
      .is_ll       (),
      .is_sc       (is_sc)
   );

   // field at the byte offset; halfwords sit at offset 0 or 2
   assign byte_sel = data_rdata[{addr_low_m, 3'b000} +: 8];
   assign half_sel = addr_low_m[1] ? data_rdata[31:16] : data_rdata[15:0];

   assign byte_sign = byte_sel[7] & ~is_unsigned;
   assign half_sign = half_sel[15] & ~is_unsigned;

   always_comb begin
      read_result_m = '0;
      if (is_sc) begin
         read_result_m = lsu_data_t'(data_scsucceed);
      end else if (!is_store && op_m != NOP) begin
         case (size)
            SIZE_B: begin
               read_result_m = {{(`LSU_DATA_BITS-8){byte_sign}}, byte_sel};
            end
            SIZE_H: begin
               read_result_m = {{(`LSU_DATA_BITS-16){half_sign}}, half_sel};
            end
            default: begin
               read_result_m = data_rdata;
            end
         endcase
      end
   end

endmodule

// File: hdl/cpu_lsu.sv
`include "lsu_consts.svh"

module cpu_lsu import lsu_op_pkg::*, mem_port_pkg::*; (
   input  logic      clk,
   input  logic      reset,

   input  logic      valid,
   input  lsu_op_e   op,
   input  lsu_data_t base,
   input  lsu_data_t offset,
   input  lsu_data_t wdata,
   input  lsu_reg_t  rd_e,
   input  logic      wen_e,

   // memory port
   output logic      data_req,
   output lsu_addr_t data_addr,
   output logic      data_wr,
   output lsu_strb_t data_wstrb,
   output lsu_data_t data_wdata,
   output logic      data_ll,
   output logic      data_sc,
   input  logic      data_addr_ok,
   output logic      data_recv,
   input  logic      data_scsucceed,
   input  lsu_data_t data_rdata,
   input  logic      data_data_ok,

   // results to the pipeline
   output logic      addr_finish,
   output logic      ale_e,
   output lsu_data_t read_result_m,
   output logic      rdata_valid_m,
   output lsu_reg_t  rd_m,
   output logic      wen_m
);

   logic       accepted;
   lsu_op_e    op_m;
   logic [1:0] addr_low_m;

   assign accepted      = data_req & data_addr_ok;
   assign rdata_valid_m = data_data_ok;

   lsu_issue issue_inst (
      .valid        (valid),
      .op           (op),
      .base         (base),
      .offset       (offset),
      .wdata        (wdata),
      .data_req     (data_req),
      .data_addr    (data_addr),
      .data_wr      (data_wr),
      .data_wstrb   (data_wstrb),
      .data_wdata   (data_wdata),
      .data_ll      (data_ll),
      .data_sc      (data_sc),
      .ale          (ale_e),
      .data_addr_ok (data_addr_ok),
      .addr_finish  (addr_finish)
   );

   lsu_mem_track mem_track_inst (
      .clk          (clk),
      .reset        (reset),
      .valid        (valid),
      .op_e         (op),
      .addr_low_e   (data_addr[1:0]),
      .rd_e         (rd_e),
      .wen_e        (wen_e),
      .accepted     (accepted),
      .data_data_ok (data_data_ok),
      .op_m         (op_m),
      .addr_low_m   (addr_low_m),
      .rd_m         (rd_m),
      .wen_m        (wen_m),
      .data_recv    (data_recv)
   );

   lsu_load_align load_align_inst (
      .op_m           (op_m),
      .addr_low_m     (addr_low_m),
      .data_rdata     (data_rdata),
      .data_scsucceed (data_scsucceed),
      .read_result_m  (read_result_m)
   );

endmodule

// File: test/tb_mem_responder.sv
`include "lsu_consts.svh"

module tb_mem_responder import mem_port_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  logic [1:0] accept_delay,
   input  logic [1:0] return_delay,
   input  logic       data_req,
   input  lsu_addr_t  data_addr,
   input  logic       data_wr,
   input  lsu_strb_t  data_wstrb,
   input  lsu_data_t  data_wdata,
   input  logic       data_ll,
   input  logic       data_sc,
   output logic       data_addr_ok,
   output logic       data_data_ok,
   output lsu_data_t  data_rdata,
   output logic       data_scsucceed
);
   timeunit 1ns;
   timeprecision 1ps;

   lsu_data_t  mem [16];
   lsu_data_t  read_q;
   logic       sc_q;
   logic       pending;
   logic [1:0] data_cnt;
   logic [2:0] req_cycles;
   logic       reserved;
   lsu_addr_t  reserve_addr;
   logic       sc_ok;
   logic [3:0] idx;
   int         w;
   int         lane;

   function automatic lsu_data_t initial_word(input logic [3:0] i);
      return {i, ~i, i + 4'h5, i ^ 4'ha, ~i, i, 4'h3 - i, i + 4'h9};
   endfunction

   assign idx   = data_addr[5:2];
   assign sc_ok = reserved && reserve_addr == data_addr;

   always @(posedge clk) begin
      if (reset) begin
         data_addr_ok   <= 1'b0;
         data_data_ok   <= 1'b0;
         data_rdata     <= '0;
         data_scsucceed <= 1'b0;
         pending        <= 1'b0;
         reserved       <= 1'b0;
         req_cycles     <= '0;
         for (w = 0; w < 16; w++) begin
            mem[w] <= initial_word(w[3:0]);
         end
      end else begin
         data_data_ok <= 1'b0;
         if (data_req && data_addr_ok) begin
            data_addr_ok <= 1'b0;
            req_cycles   <= '0;
            // a failed sc leaves memory alone
            if (data_wr && (!data_sc || sc_ok)) begin
               for (lane = 0; lane < `LSU_STRB_BITS; lane++) begin
                  if (data_wstrb[lane]) begin
                     mem[idx][8*lane +: 8] <= data_wdata[8*lane +: 8];
                  end
               end
            end
            if (data_wr) begin
               reserved <= 1'b0;
            end else if (data_ll) begin
               reserved     <= 1'b1;
               reserve_addr <= data_addr;
            end
            if (return_delay == 2'd0) begin
               data_data_ok   <= 1'b1;
               data_rdata     <= mem[idx];
               data_scsucceed <= data_sc && sc_ok;
            end else begin
               pending  <= 1'b1;
               data_cnt <= return_delay - 2'd1;
               read_q   <= mem[idx];
               sc_q     <= data_sc && sc_ok;
            end
         end else if (pending) begin
            if (data_cnt == 2'd0) begin
               pending        <= 1'b0;
               data_data_ok   <= 1'b1;
               data_rdata     <= read_q;
               data_scsucceed <= sc_q;
            end else begin
               data_cnt <= data_cnt - 2'd1;
            end
         end else if (data_req) begin
            // back-pressure for accept_delay cycles before taking the request
            if (req_cycles >= accept_delay) begin
               data_addr_ok <= 1'b1;
            end else begin
               req_cycles <= req_cycles + 3'd1;
            end
         end else begin
            req_cycles <= '0;
         end
      end
   end

endmodule

// File: test/tb_cpu_lsu.sv
`include "lsu_consts.svh"

module tb_cpu_lsu import lsu_op_pkg::*, mem_port_pkg::*;;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int WAIT_LIMIT = 20;

   logic clk, reset, valid, wen_e, data_req, data_wr, data_ll, data_sc, data_addr_ok;
   logic data_recv, data_scsucceed, data_data_ok, addr_finish, ale_e, rdata_valid_m, wen_m;
   logic [1:0] accept_delay, return_delay;
   lsu_op_e    op;
   lsu_data_t  base, offset, wdata, data_wdata, data_rdata, read_result_m, last_result;
   lsu_addr_t  data_addr, model_res_addr;
   lsu_strb_t  data_wstrb;
   lsu_reg_t   rd_e, rd_m;
   lsu_data_t  model_mem [16];
   logic       model_res;
   logic       timed_out;
   logic [15:0] lfsr;
   int         errors;
   int         checks;
   lsu_op_e    op_list [10] = '{LD_B, LD_H, LD_W, LD_BU, LD_HU, ST_B, ST_H, ST_W, LL_W, SC_W};

   cpu_lsu cpu_lsu_inst (.*);

   tb_mem_responder mem_responder_inst (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // galois lfsr stepped once per bit taken
   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] value;
      value = '0;
      for (int i = 0; i < n; i++) begin
         lfsr  = lfsr[0] ? (lfsr >> 1) ^ 16'hb400 : lfsr >> 1;
         value = {value[30:0], lfsr[0]};
      end
      return value;
   endfunction

   function automatic lsu_data_t initial_word(input logic [3:0] i);
      return {i, ~i, i + 4'h5, i ^ 4'ha, ~i, i, 4'h3 - i, i + 4'h9};
   endfunction

   function automatic int access_bytes(input lsu_op_e o);
      case (o)
         LD_B, LD_BU, ST_B: return 1;
         LD_H, LD_HU, ST_H: return 2;
         default: return 4;
      endcase
   endfunction

   function automatic logic writes(input lsu_op_e o);
      return o inside {ST_B, ST_H, ST_W, SC_W};
   endfunction

   // lanes covered by the access counted up from the byte offset
   function automatic lsu_strb_t expected_strobe(input lsu_op_e o, input lsu_addr_t a);
      lsu_strb_t s;
      s = '0;
      for (int lane = 0; lane < 4; lane++) begin
         s[lane] = writes(o) && lane >= a[1:0] && lane < a[1:0] + access_bytes(o);
      end
      return s;
   endfunction

   function automatic lsu_data_t expected_wdata(input lsu_op_e o, input lsu_data_t w);
      if (!writes(o)) return '0;
      case (access_bytes(o))
         1: return {4{w[7:0]}};
         2: return {2{w[15:0]}};
         default: return w;
      endcase
   endfunction

   function automatic lsu_data_t expected_load(input lsu_op_e o, input lsu_data_t word,
                                               input logic [1:0] low, input logic sc_ok);
      lsu_data_t field;
      field = word >> (8 * low);
      case (o)
         LD_B:       return {{24{field[7]}}, field[7:0]};
         LD_BU:      return {24'h0, field[7:0]};
         LD_H:       return {{16{field[15]}}, field[15:0]};
         LD_HU:      return {16'h0, field[15:0]};
         LD_W, LL_W: return word;
         SC_W:       return {31'h0, sc_ok};
         default:    return '0;
      endcase
   endfunction

   task automatic check_value(input string name, input logic [`LSU_DATA_BITS-1:0] got,
                              input logic [`LSU_DATA_BITS-1:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("[ERROR] %s got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic run_access(input lsu_op_e op_v, input lsu_data_t base_v,
                             input lsu_data_t offset_v, input lsu_data_t wdata_v,
                             input lsu_reg_t rd_v, input logic wen_v,
                             input logic [1:0] accept_v, input logic [1:0] return_v);
      lsu_addr_t addr;
      lsu_data_t expected;
      lsu_strb_t strb;
      logic      misaligned;
      logic      sc_ok;
      logic      done;
      int        count;
      if (timed_out) return;
      addr       = base_v + offset_v;
      misaligned = addr % access_bytes(op_v) != 0;
      @(posedge clk);
      valid        <= 1'b1;
      op           <= op_v;
      base         <= base_v;
      offset       <= offset_v;
      wdata        <= wdata_v;
      rd_e         <= rd_v;
      wen_e        <= wen_v;
      accept_delay <= accept_v;
      return_delay <= return_v;
      done  = 1'b0;
      count = 0;
      while (!done) begin
         @(negedge clk);
         check_value("ale_e", ale_e, misaligned);
         check_value("data_req", data_req, !misaligned);
         check_value("data_recv", data_recv, 1'b0);
         check_value("addr_finish", addr_finish, misaligned || data_addr_ok);
         if (!misaligned) begin
            check_value("data_addr", data_addr, addr);
            check_value("data_wr", data_wr, writes(op_v));
            check_value("data_ll", data_ll, op_v == LL_W);
            check_value("data_sc", data_sc, op_v == SC_W);
            check_value("data_wstrb", data_wstrb, expected_strobe(op_v, addr));
            check_value("data_wdata", data_wdata, expected_wdata(op_v, wdata_v));
         end
         done = addr_finish;
         if (!done && count == WAIT_LIMIT) begin
            $display("timeout: request to address %h was never accepted", addr);
            errors++;
            timed_out = 1'b1;
            return;
         end
         count++;
      end
      // model side of the access as the memory sees it at acceptance
      sc_ok    = model_res && model_res_addr == addr;
      expected = expected_load(op_v, model_mem[addr[5:2]], addr[1:0], sc_ok);
      strb     = expected_strobe(op_v, addr);
      if (!misaligned && writes(op_v) && (op_v != SC_W || sc_ok)) begin
         for (int lane = 0; lane < 4; lane++) begin
            if (strb[lane]) begin
               model_mem[addr[5:2]][8*lane +: 8] = expected_wdata(op_v, wdata_v) >> (8 * lane);
            end
         end
      end
      if (!misaligned && writes(op_v)) begin
         model_res = 1'b0;
      end else if (!misaligned && op_v == LL_W) begin
         model_res      = 1'b1;
         model_res_addr = addr;
      end
      // scramble the execute inputs to show that the memory stage holds
      @(posedge clk);
      valid <= 1'b0;
      op    <= NOP;
      rd_e  <= ~rd_v;
      wen_e <= ~wen_v;
      if (misaligned) return;
      done  = 1'b0;
      count = 0;
      while (!done) begin
         @(negedge clk);
         check_value("data_recv", data_recv, 1'b1);
         check_value("rd_m", rd_m, rd_v);
         check_value("wen_m", wen_m, wen_v);
         check_value("rdata_valid_m", rdata_valid_m, data_data_ok);
         done = data_data_ok;
         if (done) begin
            check_value("read_result_m", read_result_m, expected);
            last_result = read_result_m;
         end else if (count == WAIT_LIMIT) begin
            $display("timeout: no data returned for address %h", addr);
            errors++;
            timed_out = 1'b1;
            return;
         end
         count++;
      end
      @(negedge clk);
      check_value("data_recv", data_recv, 1'b0);
   endtask

   initial begin
      lsu_op_e    op_v;
      logic [3:0] off_bits;
      lfsr      = 16'd63;
      errors    = 0;
      checks    = 0;
      timed_out = 1'b0;
      model_res = 1'b0;
      reset     = 1'b1;
      valid     = 1'b0;
      op        = NOP;
      base      = '0;
      offset    = '0;
      wdata     = '0;
      rd_e      = '0;
      wen_e     = 1'b0;
      accept_delay = '0;
      return_delay = '0;
      for (int i = 0; i < 16; i++) begin
         model_mem[i] = initial_word(i[3:0]);
      end
      repeat (4) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      check_value("data_recv", data_recv, 1'b0);
      check_value("wen_m", wen_m, 1'b0);
      // misaligned halfword, word, ll and sc
      run_access(LD_H, 32'h1000, 32'h1, '0, 5'd1, 1'b1, 2'd0, 2'd0);
      run_access(LD_W, 32'h1000, 32'h2, '0, 5'd2, 1'b1, 2'd0, 2'd0);
      run_access(LL_W, 32'h1004, 32'h1, '0, 5'd3, 1'b1, 2'd0, 2'd0);
      run_access(SC_W, 32'h1008, 32'h3, '0, 5'd4, 1'b1, 2'd0, 2'd0);
      // every store size at every byte offset
      for (int k = 5; k < 8; k++) begin
         for (int j = 0; j < 4; j++) begin
            run_access(op_list[k], 32'h1010, j, random_bits(32), 5'd5, 1'b0, 2'd1, 2'd1);
         end
      end
      // reservation kept and then broken by a store in between
      run_access(LL_W, 32'h1020, '0, '0, 5'd6, 1'b1, 2'd3, 2'd0);
      run_access(SC_W, 32'h1020, '0, 32'hcafe_0001, 5'd7, 1'b1, 2'd0, 2'd3);
      check_value("sc result after ll", last_result, 32'h1);
      run_access(LD_W, 32'h1020, '0, '0, 5'd8, 1'b1, 2'd2, 2'd2);
      check_value("word after sc", last_result, 32'hcafe_0001);
      run_access(LL_W, 32'h1024, '0, '0, 5'd9, 1'b1, 2'd0, 2'd1);
      run_access(ST_B, 32'h1030, '0, 32'h55, 5'd10, 1'b0, 2'd1, 2'd0);
      run_access(SC_W, 32'h1024, '0, 32'h0bad_0bad, 5'd11, 1'b1, 2'd3, 2'd3);
      check_value("sc result after store", last_result, 32'h0);
      run_access(LD_W, 32'h1024, '0, '0, 5'd12, 1'b1, 2'd0, 2'd0);
      for (int n = 0; n < 200; n++) begin
         op_v     = op_list[random_bits(4) % 10];
         off_bits = random_bits(4);
         run_access(op_v, 32'h1000 + (random_bits(4) << 2), {{28{off_bits[3]}}, off_bits},
                    random_bits(32), random_bits(5), random_bits(1), random_bits(2),
                    random_bits(2));
      end
      $display("checks: %0d  errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

// File: project.f
+incdir+hdl
hdl/lsu_op_pkg.sv
hdl/mem_port_pkg.sv
hdl/lsu_op_decode.sv
hdl/lsu_issue.sv
hdl/lsu_mem_track.sv
hdl/lsu_load_align.sv
hdl/cpu_lsu.sv
test/tb_mem_responder.sv
test/tb_cpu_lsu.sv

// File: Bender.yml
package:
  name: cpu_lsu

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/lsu_op_pkg.sv
      - hdl/mem_port_pkg.sv
      - hdl/lsu_op_decode.sv
      - hdl/lsu_issue.sv
      - hdl/lsu_mem_track.sv
      - hdl/lsu_load_align.sv
      - hdl/cpu_lsu.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/tb_mem_responder.sv
      - test/tb_cpu_lsu.sv
